// ==== src/qr_consts.svh ====
`ifndef QR_CONSTS_SVH
`define QR_CONSTS_SVH

// bit buffer geometry
`define QR_BUF_DEPTH      4096

// header layout, count first then format
`define QR_HEADER_BITS    27
`define QR_COUNT_BITS     12
`define QR_INFO_BITS      15

// symbol size limits in modules per side
`define QR_MIN_SIZE       21
`define QR_MAX_SIZE       63

// cycles from matrix address to matrix bit
`define QR_MATRIX_LATENCY 1

`endif

// ==== src/qr_pkg.sv ====
`default_nettype none

package qr_pkg;

    typedef logic [5:0]  qr_size_t;
    typedef logic [5:0]  qr_coord_t;
    typedef logic [11:0] qr_matrix_addr_t;
    typedef logic [11:0] qr_buf_addr_t;
    typedef logic [11:0] qr_bit_count_t;
    typedef logic [14:0] qr_format_t;
    // mask pattern number, format bits 12 to 10
    typedef logic [2:0]  qr_mask_t;

    typedef struct packed {
        qr_size_t   size;
        qr_format_t format;
    } qr_symbol_cfg_t;

    typedef struct packed {
        logic active;
        logic valid;
        logic last;
        logic data;
    } qr_bit_beat_t;

    typedef struct packed {
        logic         en;
        qr_buf_addr_t addr;
        logic         data;
    } qr_buf_wr_t;

    typedef enum logic [2:0] {
        walk_idle,
        walk_addr,
        walk_wait,
        walk_sample,
        walk_step,
        walk_finished
    } qr_walk_state_t;

    typedef enum logic [1:0] {
        write_idle,
        write_data,
        write_header,
        write_done
    } qr_write_state_t;

endpackage

`default_nettype wire

// ==== src/qr_module_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_consts.svh"

module qr_module_walker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  qr_pkg::qr_symbol_cfg_t   cfg,
    output qr_pkg::qr_matrix_addr_t  matrix_addr,
    input  logic                     matrix_bit,
    output qr_pkg::qr_bit_beat_t     beat
);
    import qr_pkg::*;

    qr_walk_state_t state;
    qr_coord_t      row;
    // right column of the current pair
    qr_coord_t      col;
    logic           side;
    logic           up;
    logic [3:0]     wait_cnt;
    logic           data_q;

    qr_coord_t      x;
    logic           row_end;
    logic           pair_done;
    logic           last_module;

    // mask condition for module (x, y)
    function automatic logic mask_hit(input qr_mask_t mask, input qr_coord_t mx,
                                      input qr_coord_t my);
        logic [11:0] prod;
        logic [6:0]  sum;
        logic [5:0]  blk;
        logic        hit;
        prod = {6'd0, mx} * {6'd0, my};
        sum  = {1'b0, mx} + {1'b0, my};
        blk  = (mx / 6'd2) + (my / 6'd3);
        case (mask)
            3'd0: hit = ((prod % 12'd2) + (prod % 12'd3)) == 12'd0;
            3'd1: hit = blk[0] == 1'b0;
            3'd2: hit = (((prod % 12'd3) + 12'(sum % 7'd2)) % 12'd2) == 12'd0;
            3'd3: hit = (((prod % 12'd2) + (prod % 12'd3)) % 12'd2) == 12'd0;
            3'd4: hit = mx[0] == 1'b0;
            3'd5: hit = sum[0] == 1'b0;
            3'd6: hit = (sum % 7'd3) == 7'd0;
            default: hit = (my % 6'd3) == 6'd0;
        endcase
        return hit;
    endfunction

    ////////////////////
    // zigzag position

    assign x = side ? (col - 6'd1) : col;

    assign row_end     = up ? (row == '0) : (row == cfg.size - 6'd1);
    assign pair_done   = row_end && (side || (col == '0));
    assign last_module = pair_done && (col <= 6'd1);

    assign matrix_addr = qr_matrix_addr_t'(row) * qr_matrix_addr_t'(cfg.size)
                       + qr_matrix_addr_t'(x);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= walk_idle;
            row      <= '0;
            col      <= '0;
            side     <= 1'b0;
            up       <= 1'b1;
            wait_cnt <= '0;
        end else begin
            case (state)
                walk_idle: begin
                    if (start) begin
                        // bottom right corner, moving up
                        row   <= cfg.size - 6'd1;
                        col   <= cfg.size - 6'd1;
                        side  <= 1'b0;
                        up    <= 1'b1;
                        state <= walk_addr;
                    end
                end
                walk_addr: begin
                    wait_cnt <= '0;
                    state    <= walk_wait;
                end
                walk_wait: begin
                    if (wait_cnt == 4'(`QR_MATRIX_LATENCY - 1)) begin
                        state <= walk_sample;
                    end else begin
                        wait_cnt <= wait_cnt + 4'd1;
                    end
                end
                walk_sample: begin
                    state <= walk_step;
                end
                walk_step: begin
                    if (last_module) begin
                        state <= walk_finished;
                    end else begin
                        state <= walk_addr;
                        if (!side && (col != '0)) begin
                            side <= 1'b1;
                        end else begin
                            side <= 1'b0;
                            if (row_end) begin
                                // next pair, turn around
                                col <= col - 6'd2;
                                up  <= ~up;
                            end else if (up) begin
                                row <= row - 6'd1;
                            end else begin
                                row <= row + 6'd1;
                            end
                        end
                    end
                end
                walk_finished: begin
                    if (!start) begin
                        state <= walk_idle;
                    end
                end
                default: state <= walk_idle;
            endcase
        end
    end

    // unmask while the matrix bit is valid
    always_ff @(posedge clk) begin
        if (state == walk_sample) begin
            data_q <= matrix_bit ^ mask_hit(cfg.format[12:10], x, row);
        end
    end

    ////////////////////
    // beat out

    assign beat.active = (state != walk_idle);
    assign beat.valid  = (state == walk_step);
    assign beat.last   = (state == walk_step) && last_module;
    assign beat.data   = data_q;

    a_addr_in_symbol: assert property (@(posedge clk) disable iff (!rst_n)
        (state inside {walk_addr, walk_wait, walk_sample})
        |-> (matrix_addr < qr_matrix_addr_t'(cfg.size) * qr_matrix_addr_t'(cfg.size)));

    a_size_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(start) |-> (cfg.size[0] && (cfg.size >= 6'(`QR_MIN_SIZE))
                          && (cfg.size <= 6'(`QR_MAX_SIZE))));

endmodule

`default_nettype wire

// ==== src/qr_bit_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_consts.svh"

module qr_bit_buffer (
    input  logic                 clk,
    input  qr_pkg::qr_buf_wr_t   wr,
    input  qr_pkg::qr_buf_addr_t rd_addr,
    output logic                 rd_bit
);

    // stands in for a simple dual port block RAM
    logic mem [0:`QR_BUF_DEPTH-1];

    ////////////////////
    // write port

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    ////////////////////
    // read port, one cycle

    always_ff @(posedge clk) begin
        rd_bit <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/qr_stream_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_consts.svh"

module qr_stream_writer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  qr_pkg::qr_bit_beat_t   beat,
    input  qr_pkg::qr_symbol_cfg_t cfg,
    output qr_pkg::qr_buf_wr_t     wr,
    output logic                   done
);
    import qr_pkg::*;

    qr_write_state_t state;
    qr_bit_count_t   bit_count;
    logic [4:0]      hdr_idx;

    logic            wr_en_q;
    qr_buf_addr_t    wr_addr_q;
    logic            wr_data_q;

    // count in the low bits, format above, both lsb first
    logic [`QR_INFO_BITS+`QR_COUNT_BITS-1:0] header_bits;
    // one extra bit to catch overflow
    logic [12:0]     data_addr_wide;

    assign header_bits    = {cfg.format, bit_count};
    assign data_addr_wide = 13'(bit_count) + 13'(`QR_HEADER_BITS);

    ////////////////////
    // control

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= write_idle;
            bit_count <= '0;
            hdr_idx   <= '0;
            wr_en_q   <= 1'b0;
            done      <= 1'b0;
        end else if (!beat.active) begin
            state     <= write_idle;
            bit_count <= '0;
            hdr_idx   <= '0;
            wr_en_q   <= 1'b0;
            done      <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            case (state)
                write_idle: begin
                    state <= write_data;
                end
                write_data: begin
                    if (beat.valid) begin
                        wr_en_q   <= 1'b1;
                        bit_count <= bit_count + 12'd1;
                        if (beat.last) begin
                            hdr_idx <= '0;
                            state   <= write_header;
                        end
                    end
                end
                write_header: begin
                    wr_en_q <= 1'b1;
                    if (hdr_idx == 5'(`QR_HEADER_BITS - 1)) begin
                        state <= write_done;
                    end else begin
                        hdr_idx <= hdr_idx + 5'd1;
                    end
                end
                write_done: begin
                    // last header write has landed by now
                    done <= 1'b1;
                end
                default: state <= write_idle;
            endcase
        end
    end

    ////////////////////
    // write payload

    always_ff @(posedge clk) begin
        if ((state == write_data) && beat.valid) begin
            wr_addr_q <= data_addr_wide[11:0];
            wr_data_q <= beat.data;
        end else if (state == write_header) begin
            wr_addr_q <= qr_buf_addr_t'(hdr_idx);
            wr_data_q <= header_bits[hdr_idx];
        end
    end

    assign wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == write_data) && beat.active && beat.valid)
        |-> (data_addr_wide < 13'(`QR_BUF_DEPTH)));

endmodule

`default_nettype wire

// ==== src/qr_demask_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module qr_demask_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  qr_pkg::qr_symbol_cfg_t   cfg,
    output qr_pkg::qr_matrix_addr_t  matrix_addr,
    input  logic                     matrix_bit,
    input  qr_pkg::qr_buf_addr_t     rd_addr,
    output logic                     rd_bit,
    output logic                     done
);
    import qr_pkg::*;

    qr_bit_beat_t beat;
    qr_buf_wr_t   buf_wr;

    // zigzag walk and unmasking
    qr_module_walker u_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .matrix_addr (matrix_addr),
        .matrix_bit  (matrix_bit),
        .beat        (beat)
    );

    // data then header into the buffer
    qr_stream_writer u_writer (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .cfg   (cfg),
        .wr    (buf_wr),
        .done  (done)
    );

    qr_bit_buffer u_buffer (
        .clk     (clk),
        .wr      (buf_wr),
        .rd_addr (rd_addr),
        .rd_bit  (rd_bit)
    );

endmodule

`default_nettype wire

// ==== sim/qr_demask_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qr_consts.svh"

module qr_demask_tb;
    import qr_pkg::*;

    typedef struct packed {
        qr_size_t   size;
        qr_format_t format;
        qr_mask_t   mask;
    } test_case_t;

    localparam int NUM_CASES = 8;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            start;
    qr_symbol_cfg_t  cfg;
    qr_matrix_addr_t matrix_addr;
    logic            matrix_bit = 1'b0;
    qr_buf_addr_t    rd_addr;
    logic            rd_bit;
    logic            done;

    // whole 12-bit matrix address space
    logic            matrix_mem [0:4095];
    qr_matrix_addr_t matrix_addr_q = '0;
    logic            exp_bits [0:`QR_BUF_DEPTH-1];
    integer          seed;

    // masks 0 to 7 in turn with a smaller symbol after a larger one
    test_case_t cases [0:NUM_CASES-1] = '{
        '{size: 6'd21, format: {2'b01, 3'd0, 10'h1d4}, mask: 3'd0},
        '{size: 6'd25, format: {2'b00, 3'd1, 10'h2a7}, mask: 3'd1},
        '{size: 6'd33, format: {2'b11, 3'd2, 10'h0f3}, mask: 3'd2},
        '{size: 6'd21, format: {2'b10, 3'd3, 10'h35b}, mask: 3'd3},
        '{size: 6'd29, format: {2'b01, 3'd4, 10'h16c}, mask: 3'd4},
        '{size: 6'd25, format: {2'b00, 3'd5, 10'h3e1}, mask: 3'd5},
        '{size: 6'd23, format: {2'b11, 3'd6, 10'h08d}, mask: 3'd6},
        '{size: 6'd63, format: {2'b10, 3'd7, 10'h279}, mask: 3'd7}
    };

    qr_demask_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .matrix_addr (matrix_addr),
        .matrix_bit  (matrix_bit),
        .rd_addr     (rd_addr),
        .rd_bit      (rd_bit),
        .done        (done)
    );

    always #10 clk = ~clk;

    ////////////////////
    // matrix memory model

    // address taken on the rising edge and bit out on the falling edge
    always @(posedge clk) begin
        matrix_addr_q <= matrix_addr;
    end

    always @(negedge clk) begin
        matrix_bit <= matrix_mem[matrix_addr_q];
    end

    task automatic fill_matrix();
        logic [31:0] word;
        for (int a = 0; a < 4096; a++) begin
            word = $random(seed);
            matrix_mem[a] = word[16];
        end
    endtask

    ////////////////////
    // reference model

    // x is the column and y the row
    function automatic logic mask_condition(input qr_mask_t m, input int x, input int y);
        int   p;
        logic hit;
        p = x * y;
        case (m)
            3'd0: hit = ((p % 2) + (p % 3)) == 0;
            3'd1: hit = (((x / 2) + (y / 3)) % 2) == 0;
            3'd2: hit = (((p % 3) + ((x + y) % 2)) % 2) == 0;
            3'd3: hit = (((p % 2) + (p % 3)) % 2) == 0;
            3'd4: hit = (x % 2) == 0;
            3'd5: hit = ((x + y) % 2) == 0;
            3'd6: hit = ((x + y) % 3) == 0;
            default: hit = (y % 3) == 0;
        endcase
        return hit;
    endfunction

    // column pairs from the right going upward first with column 0 alone at the end
    task automatic build_expected(input test_case_t tc, output int n_bits);
        int s;
        int r;
        int pair;
        s      = int'(tc.size);
        n_bits = 0;
        pair   = 0;
        for (int c = s - 1; c >= 0; c -= 2) begin
            for (int k = 0; k < s; k++) begin
                r = (pair % 2 == 0) ? (s - 1 - k) : k;
                exp_bits[n_bits] = matrix_mem[r * s + c] ^ mask_condition(tc.mask, c, r);
                n_bits++;
                if (c > 0) begin
                    exp_bits[n_bits] = matrix_mem[r * s + c - 1]
                                     ^ mask_condition(tc.mask, c - 1, r);
                    n_bits++;
                end
            end
            pair++;
        end
    endtask

    ////////////////////
    // checks

    task automatic end_in_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_count(input string name, input qr_bit_count_t expected,
                               input qr_bit_count_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %0d, actual %0d", name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_format(input string name, input qr_format_t expected,
                                input qr_format_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error %s: expected %b, actual %b", name, expected, actual);
            end_in_failure();
        end
    endtask

    // called on a falling edge and returns one falling edge later
    task automatic read_buffer_bit(input int addr, output logic value);
        rd_addr = qr_buf_addr_t'(addr);
        @(negedge clk);
        value = rd_bit;
    endtask

    task automatic run_case(input int idx, input test_case_t tc);
        int            s;
        int            n_bits;
        int            cycles;
        logic          b;
        qr_bit_count_t count_rd;
        qr_format_t    format_rd;
        string         tag;
        s   = int'(tc.size);
        tag = $sformatf("case %0d size %0d mask %0d", idx, s, tc.mask);
        fill_matrix();
        build_expected(tc, n_bits);
        cfg   = '{size: tc.size, format: tc.format};
        start = 1'b1;
        @(negedge clk);
        check_bit({tag, " done right after start"}, 1'b0, done);
        cycles = 1;
        while ((done !== 1'b1) && (cycles <= 4 * s * s + 100)) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("%s: done did not rise within the walk time", tag);
            end_in_failure();
        end
        if (cycles < 4 * s * s) begin
            $display("%s: done rose after %0d cycles, before the walk could end", tag, cycles);
            end_in_failure();
        end
        // header holds the count then the format
        for (int k = 0; k < `QR_COUNT_BITS; k++) begin
            read_buffer_bit(k, b);
            count_rd[k] = b;
        end
        for (int k = 0; k < `QR_INFO_BITS; k++) begin
            read_buffer_bit(`QR_COUNT_BITS + k, b);
            format_rd[k] = b;
        end
        check_count({tag, " count"}, qr_bit_count_t'(s * s), count_rd);
        check_format({tag, " format"}, tc.format, format_rd);
        for (int k = 0; k < n_bits; k++) begin
            read_buffer_bit(`QR_HEADER_BITS + k, b);
            if (k >= n_bits - s) begin
                check_bit($sformatf("%s column 0 bit %0d", tag, k), exp_bits[k], b);
            end else begin
                check_bit($sformatf("%s data bit %0d", tag, k), exp_bits[k], b);
            end
        end
        start  = 1'b0;
        cycles = 0;
        while ((done !== 1'b0) && (cycles < 10)) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b0) begin
            $display("%s: done stayed high after start dropped", tag);
            end_in_failure();
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        seed    = 32'h371d;
        rst_n   = 1'b0;
        start   = 1'b0;
        cfg     = '0;
        rd_addr = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("done after reset", 1'b0, done);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i, cases[i]);
        end
        $display("Simulation PASSED");
        $finish;
    end

    // walk, readback and slack for every case
    initial begin
        int budget;
        budget = 10;
        for (int i = 0; i < NUM_CASES; i++) begin
            budget += 5 * int'(cases[i].size) * int'(cases[i].size) + 200;
        end
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, the cases did not finish", budget);
        end_in_failure();
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/qr_pkg.sv
src/qr_module_walker.sv
src/qr_bit_buffer.sv
src/qr_stream_writer.sv
src/qr_demask_top.sv
sim/qr_demask_tb.sv

// ==== Makefile ====
TOP := qr_demask_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -j 0 \
		-f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir
